// ==== Bender.yml ====
package:
  name: isc_scheduler

sources:
  - rtl/isc_pkg.sv
  - rtl/isc_evt_cnt.sv
  - rtl/isc_query_fsm.sv
  - rtl/isc_pool.sv
  - rtl/isc_dispatch.sv
  - rtl/isc_ack_stream.sv
  - rtl/isc_scheduler.sv
  - target: test
    files:
      - testbench/isc_checker.sv
      - testbench/tb_isc_scheduler.sv

// ==== isc_scheduler.f ====
rtl/isc_pkg.sv
rtl/isc_evt_cnt.sv
rtl/isc_query_fsm.sv
rtl/isc_pool.sv
rtl/isc_dispatch.sv
rtl/isc_ack_stream.sv
rtl/isc_scheduler.sv
testbench/isc_checker.sv
testbench/tb_isc_scheduler.sv

// ==== rtl/isc_ack_stream.sv ====
`default_nettype none
`timescale 1ns/100ps

module isc_ack_stream
  import isc_pkg::*;
(
  input  wire logic clk,
  input  wire logic s_rst_n,

  // One pulse per completed SYNC
  input  wire logic sync_done_i,

  // Pseudo-stream toward the host
  input  wire logic ack_rdy_i,
  output logic      ack_vld_o,
  output ack_cnt_t  ack_cnt_o
);

  ack_cnt_t cnt_q;
  logic     hs;

  assign hs = ack_vld_o && ack_rdy_i;

  // Restart on handshake, keep a SYNC that completes in the same cycle
  always_ff @(posedge clk) begin
    if (!s_rst_n) begin
      cnt_q <= '0;
    end else if (hs) begin
      cnt_q <= ack_cnt_t'(sync_done_i);
    end else begin
      cnt_q <= cnt_q + ack_cnt_t'(sync_done_i);
    end
  end

  assign ack_vld_o = |cnt_q;
  assign ack_cnt_o = cnt_q;

endmodule

`default_nettype wire

// ==== rtl/isc_dispatch.sv ====
`default_nettype none
`timescale 1ns/100ps

module isc_dispatch
  import isc_pkg::*;
(
  input  wire logic             clk,
  input  wire logic             s_rst_n,

  // Load request from the query FSM
  input  wire logic [PE_NB-1:0] ld_i,
  input  wire insn_t            insn_i,

  // PE side
  input  wire logic             pem_rdy_i,
  input  wire logic             pea_rdy_i,
  input  wire logic             pep_rdy_i,
  output logic                  pem_vld_o,
  output logic                  pea_vld_o,
  output logic                  pep_vld_o,
  output insn_t                 pem_insn_o,
  output insn_t                 pea_insn_o,
  output insn_t                 pep_insn_o,

  output logic [PE_NB-1:0]      busy_o
);

  logic [PE_NB-1:0] rdy;
  logic [PE_NB-1:0] vld_q;
  insn_t            insn_q [PE_NB];

  assign rdy[PE_MEM]   = pem_rdy_i;
  assign rdy[PE_ARITH] = pea_rdy_i;
  assign rdy[PE_PBS]   = pep_rdy_i;

  // Full flag, clears on acceptance by the PE
  always_ff @(posedge clk) begin
    if (!s_rst_n) begin
      vld_q <= '0;
    end else begin
      for (int p = 0; p < PE_NB; p++) begin
        if (ld_i[p])
          vld_q[p] <= 1'b1;
        else if (vld_q[p] && rdy[p])
          vld_q[p] <= 1'b0;
      end
    end
  end

  // Payload held stable until accepted
  always_ff @(posedge clk) begin
    for (int p = 0; p < PE_NB; p++) begin
      if (ld_i[p])
        insn_q[p] <= insn_i;
    end
  end

  assign busy_o = vld_q;

  assign pem_vld_o  = vld_q[PE_MEM];
  assign pea_vld_o  = vld_q[PE_ARITH];
  assign pep_vld_o  = vld_q[PE_PBS];
  assign pem_insn_o = insn_q[PE_MEM];
  assign pea_insn_o = insn_q[PE_ARITH];
  assign pep_insn_o = insn_q[PE_PBS];

endmodule

`default_nettype wire

// ==== rtl/isc_evt_cnt.sv ====
`default_nettype none
`timescale 1ns/100ps

module isc_evt_cnt
  import isc_pkg::*;
(
  input  wire logic clk,
  input  wire logic s_rst_n,

  // Completion pulse from the PE
  input  wire logic evt_i,
  // One completion consumed by a retire
  input  wire logic dec_i,
  output logic      pend_o
);

  evt_cnt_t cnt_q;

  // Pulse and retire in the same cycle cancel out
  always_ff @(posedge clk) begin
    if (!s_rst_n) begin
      cnt_q <= '0;
    end else begin
      case ({evt_i, dec_i})
        2'b10:   cnt_q <= cnt_q + 1'b1;
        2'b01:   cnt_q <= cnt_q - 1'b1;
        default: cnt_q <= cnt_q;
      endcase
    end
  end

  // At least one completion waits for its retire
  assign pend_o = |cnt_q;

endmodule

`default_nettype wire

// ==== rtl/isc_pkg.sv ====
`default_nettype none

package isc_pkg;

  // ----------------------------------------------------------------------
  // Instruction format
  // ----------------------------------------------------------------------
  localparam int INSN_W = 16;
  typedef logic [INSN_W-1:0] insn_t;

  localparam int REG_ID_W = 4;
  typedef logic [REG_ID_W-1:0] reg_id_t;

  // Field positions inside insn_t
  // [15:14] kind, [13:10] dst, [9:6] srcA, [5:2] srcB, [1:0] tag
  localparam int KIND_MSB = 15;
  localparam int DST_LSB  = 10;
  localparam int SRCA_LSB = 6;
  localparam int SRCB_LSB = 2;

  // Kind encoding, value minus one gives the PE index for non-SYNC kinds
  typedef enum logic [1:0] {
    KIND_SYNC  = 2'd0,
    KIND_MEM   = 2'd1,
    KIND_ARITH = 2'd2,
    KIND_PBS   = 2'd3
  } kind_e;

  // ----------------------------------------------------------------------
  // Pool and counters
  // ----------------------------------------------------------------------
  localparam int POOL_SLOT_NB = 4;
  localparam int POOL_SLOT_W  = 2;
  // Zero to four free slots
  typedef logic [POOL_SLOT_W:0] free_cnt_t;

  // Enough for every instruction that can be in flight
  localparam int EVT_CNT_W = 3;
  typedef logic [EVT_CNT_W-1:0] evt_cnt_t;

  localparam int ACK_CNT_W = 16;
  typedef logic [ACK_CNT_W-1:0] ack_cnt_t;

  // ----------------------------------------------------------------------
  // Processing elements
  // ----------------------------------------------------------------------
  localparam int PE_NB    = 3;
  localparam int PE_MEM   = 0;
  localparam int PE_ARITH = 1;
  localparam int PE_PBS   = 2;

  // Commands issued by the query FSM toward the pool
  typedef enum logic [1:0] {
    CMD_RETIRE,
    CMD_REFILL,
    CMD_ISSUE,
    CMD_NONE
  } cmd_e;

  typedef enum logic [1:0] {
    ST_SELECT,
    ST_EXEC
  } fsm_state_e;

endpackage

`default_nettype wire

// ==== rtl/isc_pool.sv ====
`default_nettype none
`timescale 1ns/100ps

module isc_pool
  import isc_pkg::*;
(
  input  wire logic             clk,
  input  wire logic             s_rst_n,

  // Commands, one per execute cycle
  input  wire insn_t            insn_i,
  input  wire logic             refill_i,
  input  wire logic             issue_i,
  input  wire logic             retire_i,
  input  wire kind_e            sel_kind_i,
  input  wire logic [PE_NB-1:0] pe_busy_i,

  // Status and candidates
  output free_cnt_t             free_slot_o,
  output logic [PE_NB-1:0]      issue_cand_o,
  output logic                  sync_cand_o,
  output insn_t                 issue_insn_o
);

  // Slot 0 is the oldest entry
  logic [POOL_SLOT_NB-1:0] vld_q;
  logic [POOL_SLOT_NB-1:0] iss_q;
  insn_t                   insn_q [POOL_SLOT_NB];
  logic [POOL_SLOT_NB-1:0] vld_d;
  logic [POOL_SLOT_NB-1:0] iss_d;
  insn_t                   insn_d [POOL_SLOT_NB];

  logic [POOL_SLOT_NB-1:0] blocked;
  logic [POOL_SLOT_NB-1:0] ready;
  free_cnt_t               used;
  logic                    iss_hit;
  logic [POOL_SLOT_W-1:0]  iss_idx;
  logic                    ret_hit;
  logic [POOL_SLOT_W-1:0]  ret_idx;
  logic                    free_en;
  logic [POOL_SLOT_W-1:0]  free_idx;

  function automatic kind_e slot_kind(input insn_t insn);
    return kind_e'(insn[KIND_MSB -: $bits(kind_e)]);
  endfunction

  // Register conflict of a younger entry against an older one
  function automatic logic hazard(input insn_t older, input insn_t younger);
    reg_id_t o_dst;
    reg_id_t o_sa;
    reg_id_t o_sb;
    reg_id_t y_dst;
    reg_id_t y_sa;
    reg_id_t y_sb;
    o_dst = older[DST_LSB +: REG_ID_W];
    o_sa  = older[SRCA_LSB +: REG_ID_W];
    o_sb  = older[SRCB_LSB +: REG_ID_W];
    y_dst = younger[DST_LSB +: REG_ID_W];
    y_sa  = younger[SRCA_LSB +: REG_ID_W];
    y_sb  = younger[SRCB_LSB +: REG_ID_W];
    // RAW, WAR and WAW
    return (o_dst == y_sa) || (o_dst == y_sb) ||
           (o_sa == y_dst) || (o_sb == y_dst) || (o_dst == y_dst);
  endfunction

  // ----------------------------------------------------------------------
  // Hazard check against every older entry
  // ----------------------------------------------------------------------
  always_comb begin
    for (int i = 0; i < POOL_SLOT_NB; i++) begin
      blocked[i] = 1'b0;
      for (int j = 0; j < i; j++) begin
        if (vld_q[j] && hazard(insn_q[j], insn_q[i]))
          blocked[i] = 1'b1;
        // Same kind issues in age order, so retire order matches ack order
        if (vld_q[j] && !iss_q[j] && (slot_kind(insn_q[j]) == slot_kind(insn_q[i])))
          blocked[i] = 1'b1;
      end
      ready[i] = vld_q[i] && !iss_q[i] && !blocked[i];
    end
  end

  // Oldest match wins, scan from youngest down
  always_comb begin
    issue_cand_o = '0;
    used         = '0;
    iss_hit      = 1'b0;
    iss_idx      = '0;
    ret_hit      = 1'b0;
    ret_idx      = '0;
    for (int i = POOL_SLOT_NB-1; i >= 0; i--) begin
      if (vld_q[i])
        used = used + 1'b1;
      for (int p = 0; p < PE_NB; p++) begin
        if (ready[i] && (slot_kind(insn_q[i]) == kind_e'(p + 1)) && !pe_busy_i[p])
          issue_cand_o[p] = 1'b1;
      end
      if (ready[i] && (slot_kind(insn_q[i]) == sel_kind_i)) begin
        iss_hit = 1'b1;
        iss_idx = POOL_SLOT_W'(i);
      end
      if (vld_q[i] && iss_q[i] && (slot_kind(insn_q[i]) == sel_kind_i)) begin
        ret_hit = 1'b1;
        ret_idx = POOL_SLOT_W'(i);
      end
    end
  end

  assign free_slot_o  = free_cnt_t'(POOL_SLOT_NB) - used;
  assign sync_cand_o  = vld_q[0] && (slot_kind(insn_q[0]) == KIND_SYNC);
  assign issue_insn_o = insn_q[iss_idx];

  // ----------------------------------------------------------------------
  // Slot update and collapse
  // ----------------------------------------------------------------------
  always_comb begin
    vld_d    = vld_q;
    iss_d    = iss_q;
    insn_d   = insn_q;
    free_en  = 1'b0;
    free_idx = '0;
    if (issue_i && (sel_kind_i == KIND_SYNC)) begin
      // SYNC is done once issued, slot 0 goes away
      free_en = 1'b1;
    end else if (issue_i && iss_hit) begin
      iss_d[iss_idx] = 1'b1;
    end
    if (retire_i && ret_hit) begin
      free_en  = 1'b1;
      free_idx = ret_idx;
    end
    // Shift younger entries down over the freed slot
    if (free_en) begin
      for (int i = 0; i < POOL_SLOT_NB-1; i++) begin
        if (i >= free_idx) begin
          vld_d[i]  = vld_q[i+1];
          iss_d[i]  = iss_q[i+1];
          insn_d[i] = insn_q[i+1];
        end
      end
      vld_d[POOL_SLOT_NB-1] = 1'b0;
      iss_d[POOL_SLOT_NB-1] = 1'b0;
    end
    // Append behind the youngest valid entry
    if (refill_i) begin
      vld_d[used[POOL_SLOT_W-1:0]]  = 1'b1;
      iss_d[used[POOL_SLOT_W-1:0]]  = 1'b0;
      insn_d[used[POOL_SLOT_W-1:0]] = insn_i;
    end
  end

  always_ff @(posedge clk) begin
    if (!s_rst_n) begin
      vld_q <= '0;
      iss_q <= '0;
    end else begin
      vld_q <= vld_d;
      iss_q <= iss_d;
    end
  end

  always_ff @(posedge clk) begin
    insn_q <= insn_d;
  end

endmodule

`default_nettype wire

// ==== rtl/isc_query_fsm.sv ====
`default_nettype none
`timescale 1ns/100ps

module isc_query_fsm
  import isc_pkg::*;
(
  input  wire logic             clk,
  input  wire logic             s_rst_n,

  // Request sources
  input  wire logic [PE_NB-1:0] ack_pend_i,
  input  wire logic             insn_vld_i,
  input  wire free_cnt_t        free_slot_i,
  input  wire logic [PE_NB-1:0] issue_cand_i,
  input  wire logic             sync_cand_i,

  // Pool command strobes
  output logic                  retire_o,
  output logic                  refill_o,
  output logic                  issue_o,
  output kind_e                 sel_kind_o,

  // Side effects of the executed command
  output logic                  insn_rdy_o,
  output logic [PE_NB-1:0]      ack_dec_o,
  output logic [PE_NB-1:0]      dispatch_ld_o,
  output logic                  sync_done_o
);

  fsm_state_e       state_q;
  cmd_e             cmd_q;
  cmd_e             cmd_d;
  kind_e            kind_q;
  kind_e            kind_d;
  logic             exec;
  logic [PE_NB-1:0] kind_oh;

  // ----------------------------------------------------------------------
  // Arbitration, retire over refill over issue
  // ----------------------------------------------------------------------
  always_comb begin
    cmd_d  = CMD_NONE;
    kind_d = KIND_SYNC;
    if (|ack_pend_i) begin
      cmd_d = CMD_RETIRE;
      // Lowest PE index wins
      for (int p = PE_NB-1; p >= 0; p--) begin
        if (ack_pend_i[p])
          kind_d = kind_e'(p + 1);
      end
    end else if (insn_vld_i && (free_slot_i != '0)) begin
      cmd_d = CMD_REFILL;
    end else if (sync_cand_i) begin
      // SYNC sits in slot 0, nothing older is left
      cmd_d  = CMD_ISSUE;
      kind_d = KIND_SYNC;
    end else if (|issue_cand_i) begin
      cmd_d = CMD_ISSUE;
      for (int p = PE_NB-1; p >= 0; p--) begin
        if (issue_cand_i[p])
          kind_d = kind_e'(p + 1);
      end
    end
  end

  // Two cycles per command, select then execute
  always_ff @(posedge clk) begin
    if (!s_rst_n) begin
      state_q <= ST_SELECT;
      cmd_q   <= CMD_NONE;
      kind_q  <= KIND_SYNC;
    end else begin
      case (state_q)
        ST_SELECT: begin
          cmd_q   <= cmd_d;
          kind_q  <= kind_d;
          state_q <= ST_EXEC;
        end
        default: begin
          state_q <= ST_SELECT;
        end
      endcase
    end
  end

  // ----------------------------------------------------------------------
  // Execute strobes
  // ----------------------------------------------------------------------
  assign exec = (state_q == ST_EXEC);

  // PE one-hot of the registered kind, zero for SYNC
  always_comb begin
    for (int p = 0; p < PE_NB; p++)
      kind_oh[p] = (kind_q == kind_e'(p + 1));
  end

  assign retire_o   = exec && (cmd_q == CMD_RETIRE);
  assign issue_o    = exec && (cmd_q == CMD_ISSUE);
  assign sel_kind_o = kind_q;

  // Ready pulse toward the host
  assign insn_rdy_o = exec && (cmd_q == CMD_REFILL);
  // Pool only appends what was really transferred
  assign refill_o   = insn_rdy_o && insn_vld_i;

  assign ack_dec_o     = {PE_NB{retire_o}} & kind_oh;
  assign dispatch_ld_o = {PE_NB{issue_o}} & kind_oh;
  assign sync_done_o   = issue_o && (kind_q == KIND_SYNC);

endmodule

`default_nettype wire

// ==== rtl/isc_scheduler.sv ====
`default_nettype none
`timescale 1ns/100ps

module isc_scheduler
  import isc_pkg::*;
(
  input  wire logic  clk,
  input  wire logic  s_rst_n,

  // Instruction stream
  input  wire insn_t insn_i,
  input  wire logic  insn_vld_i,
  output logic       insn_rdy_o,

  // SYNC ack pseudo-stream
  input  wire logic  ack_rdy_i,
  output logic       ack_vld_o,
  output ack_cnt_t   ack_cnt_o,

  // Memory PE
  input  wire logic  pem_rdy_i,
  output logic       pem_vld_o,
  output insn_t      pem_insn_o,
  input  wire logic  pem_ack_i,

  // Arithmetic PE
  input  wire logic  pea_rdy_i,
  output logic       pea_vld_o,
  output insn_t      pea_insn_o,
  input  wire logic  pea_ack_i,

  // Bootstrapping PE
  input  wire logic  pep_rdy_i,
  output logic       pep_vld_o,
  output insn_t      pep_insn_o,
  input  wire logic  pep_ack_i
);

  logic [PE_NB-1:0] ack_pend;
  logic [PE_NB-1:0] ack_dec;
  logic [PE_NB-1:0] issue_cand;
  logic [PE_NB-1:0] dispatch_ld;
  logic [PE_NB-1:0] pe_busy;
  logic             sync_cand;
  logic             sync_done;
  logic             retire;
  logic             refill;
  logic             issue;
  kind_e            sel_kind;
  free_cnt_t        free_slot;
  insn_t            issue_insn;

  // ----------------------------------------------------------------------
  // Completion counters, one per PE
  // ----------------------------------------------------------------------
  isc_evt_cnt i_evt_mem (
    .clk     (clk),
    .s_rst_n (s_rst_n),
    .evt_i   (pem_ack_i),
    .dec_i   (ack_dec[PE_MEM]),
    .pend_o  (ack_pend[PE_MEM])
  );

  isc_evt_cnt i_evt_arith (
    .clk     (clk),
    .s_rst_n (s_rst_n),
    .evt_i   (pea_ack_i),
    .dec_i   (ack_dec[PE_ARITH]),
    .pend_o  (ack_pend[PE_ARITH])
  );

  isc_evt_cnt i_evt_pbs (
    .clk     (clk),
    .s_rst_n (s_rst_n),
    .evt_i   (pep_ack_i),
    .dec_i   (ack_dec[PE_PBS]),
    .pend_o  (ack_pend[PE_PBS])
  );

  // ----------------------------------------------------------------------
  // Query FSM and pool
  // ----------------------------------------------------------------------
  isc_query_fsm i_query_fsm (
    .clk           (clk),
    .s_rst_n       (s_rst_n),
    .ack_pend_i    (ack_pend),
    .insn_vld_i    (insn_vld_i),
    .free_slot_i   (free_slot),
    .issue_cand_i  (issue_cand),
    .sync_cand_i   (sync_cand),
    .retire_o      (retire),
    .refill_o      (refill),
    .issue_o       (issue),
    .sel_kind_o    (sel_kind),
    .insn_rdy_o    (insn_rdy_o),
    .ack_dec_o     (ack_dec),
    .dispatch_ld_o (dispatch_ld),
    .sync_done_o   (sync_done)
  );

  isc_pool i_pool (
    .clk          (clk),
    .s_rst_n      (s_rst_n),
    .insn_i       (insn_i),
    .refill_i     (refill),
    .issue_i      (issue),
    .retire_i     (retire),
    .sel_kind_i   (sel_kind),
    .pe_busy_i    (pe_busy),
    .free_slot_o  (free_slot),
    .issue_cand_o (issue_cand),
    .sync_cand_o  (sync_cand),
    .issue_insn_o (issue_insn)
  );

  // ----------------------------------------------------------------------
  // Output side
  // ----------------------------------------------------------------------
  isc_dispatch i_dispatch (
    .clk        (clk),
    .s_rst_n    (s_rst_n),
    .ld_i       (dispatch_ld),
    .insn_i     (issue_insn),
    .pem_rdy_i  (pem_rdy_i),
    .pea_rdy_i  (pea_rdy_i),
    .pep_rdy_i  (pep_rdy_i),
    .pem_vld_o  (pem_vld_o),
    .pea_vld_o  (pea_vld_o),
    .pep_vld_o  (pep_vld_o),
    .pem_insn_o (pem_insn_o),
    .pea_insn_o (pea_insn_o),
    .pep_insn_o (pep_insn_o),
    .busy_o     (pe_busy)
  );

  isc_ack_stream i_ack_stream (
    .clk         (clk),
    .s_rst_n     (s_rst_n),
    .sync_done_i (sync_done),
    .ack_rdy_i   (ack_rdy_i),
    .ack_vld_o   (ack_vld_o),
    .ack_cnt_o   (ack_cnt_o)
  );

endmodule

`default_nettype wire

// ==== testbench/isc_checker.sv ====
`default_nettype none
`timescale 1ns/100ps

module isc_checker
  import isc_pkg::*;
#(
  parameter int INSN_NB = 300
) (
  input  wire logic  clk,
  input  wire logic  s_rst_n,
  // Input stream as seen at the DUT
  input  wire insn_t insn_i,
  input  wire logic  insn_vld_i,
  input  wire logic  insn_rdy_i,
  // PE ports
  input  wire logic  pem_vld_i,
  input  wire logic  pem_rdy_i,
  input  wire insn_t pem_insn_i,
  input  wire logic  pem_ack_i,
  input  wire logic  pea_vld_i,
  input  wire logic  pea_rdy_i,
  input  wire insn_t pea_insn_i,
  input  wire logic  pea_ack_i,
  input  wire logic  pep_vld_i,
  input  wire logic  pep_rdy_i,
  input  wire insn_t pep_insn_i,
  input  wire logic  pep_ack_i,
  // SYNC ack pseudo-stream
  input  wire logic  ack_vld_i,
  input  wire logic  ack_rdy_i,
  input  wire ack_cnt_t ack_cnt_i,
  // Run control
  input  wire logic  end_i,
  output logic       drained_o,
  output logic       done_o,
  output int         err_cnt_o
);

  logic [PE_NB-1:0] vld;
  logic [PE_NB-1:0] rdy;
  logic [PE_NB-1:0] ack;
  insn_t            pe_insn [PE_NB];

  // Program order as taken at the input handshake
  insn_t prog     [INSN_NB];
  bit    accepted [INSN_NB];
  bit    acked    [INSN_NB];
  // Per PE acceptance order, flat PE_NB x INSN_NB
  int    acc_order [PE_NB*INSN_NB];
  int    acc_nb    [PE_NB];
  int    ack_nb    [PE_NB];
  // Back-pressure tracking
  bit    hold_vld  [PE_NB];
  insn_t hold_insn [PE_NB];

  int n_in;
  int n_sync;
  int n_nonsync;
  int n_acked;
  int ack_sum;
  bit rst_seen;
  bit rst_prev;

  assign vld = {pep_vld_i, pea_vld_i, pem_vld_i};
  assign rdy = {pep_rdy_i, pea_rdy_i, pem_rdy_i};
  assign ack = {pep_ack_i, pea_ack_i, pem_ack_i};
  assign pe_insn[PE_MEM]   = pem_insn_i;
  assign pe_insn[PE_ARITH] = pea_insn_i;
  assign pe_insn[PE_PBS]   = pep_insn_i;

  // Everything taken in, every PE instruction acked, every SYNC reported
  assign drained_o = (n_in == INSN_NB) && (n_acked == n_nonsync) && (ack_sum == n_sync);

  initial begin
    n_in      = 0;
    n_sync    = 0;
    n_nonsync = 0;
    n_acked   = 0;
    ack_sum   = 0;
    rst_seen  = 1'b0;
    rst_prev  = 1'b0;
    done_o    = 1'b0;
    err_cnt_o = 0;
    for (int p = 0; p < PE_NB; p++) begin
      acc_nb[p]   = 0;
      ack_nb[p]   = 0;
      hold_vld[p] = 1'b0;
    end
  end

  // ----------------------------------------------------------------------
  // Reference model
  // ----------------------------------------------------------------------
  // PE index from the kind field, -1 for SYNC
  function automatic int expected_pe(input insn_t insn);
    case (insn[KIND_MSB -: 2])
      KIND_MEM:   return PE_MEM;
      KIND_ARITH: return PE_ARITH;
      KIND_PBS:   return PE_PBS;
      default:    return -1;
    endcase
  endfunction

  // Younger must wait for older on RAW, WAR or WAW
  function automatic bit conflicts(input insn_t older, input insn_t younger);
    reg_id_t od;
    reg_id_t oa;
    reg_id_t ob;
    reg_id_t yd;
    reg_id_t ya;
    reg_id_t yb;
    od = older[DST_LSB +: REG_ID_W];
    oa = older[SRCA_LSB +: REG_ID_W];
    ob = older[SRCB_LSB +: REG_ID_W];
    yd = younger[DST_LSB +: REG_ID_W];
    ya = younger[SRCA_LSB +: REG_ID_W];
    yb = younger[SRCB_LSB +: REG_ID_W];
    return (od == ya) || (od == yb) || (yd == oa) || (yd == ob) || (od == yd);
  endfunction

  // SYNCs ahead of the oldest un-acked PE instruction
  function automatic int eligible_syncs();
    int cnt;
    cnt = 0;
    for (int k = 0; k < n_in; k++) begin
      if (expected_pe(prog[k]) >= 0 && !acked[k])
        return cnt;
      if (expected_pe(prog[k]) < 0)
        cnt++;
    end
    return cnt;
  endfunction

  function automatic string pe_name(input int p);
    case (p)
      PE_MEM:   return "pem";
      PE_ARITH: return "pea";
      default:  return "pep";
    endcase
  endfunction

  // ----------------------------------------------------------------------
  // Error reporting
  // ----------------------------------------------------------------------
  task automatic report_mismatch(input string test, input logic [31:0] exp,
                                 input logic [31:0] act);
    err_cnt_o++;
    $display("** Error %s: expected %0h actual %0h at %0t", test, exp, act, $time);
  endtask

  task automatic report_failure(input string msg);
    err_cnt_o++;
    $display("Failure at %0t: %s", $time, msg);
  endtask

  // Map one PE acceptance back to program order
  task automatic check_accept(input int p, input insn_t insn);
    int j;
    j = -1;
    for (int k = 0; k < n_in; k++) begin
      if (j < 0 && !accepted[k] && expected_pe(prog[k]) >= 0 && prog[k] == insn)
        j = k;
    end
    if (j < 0) begin
      report_failure($sformatf("%s accepted %h which is not waiting in program order",
                               pe_name(p), insn));
    end else begin
      accepted[j] = 1'b1;
      if (expected_pe(prog[j]) != p)
        report_mismatch($sformatf("routing #%0d", j), expected_pe(prog[j]), p);
      acc_order[p*INSN_NB + acc_nb[p]] = j;
      acc_nb[p]++;
      // Conflicting older PE instructions must be done already
      for (int k = 0; k < j; k++) begin
        if (expected_pe(prog[k]) >= 0 && !acked[k] && conflicts(prog[k], prog[j]))
          report_mismatch($sformatf("hazard #%0d after #%0d acked", j, k), 1, 0);
      end
    end
  endtask

  // ----------------------------------------------------------------------
  // Scoreboard
  // ----------------------------------------------------------------------
  always @(posedge clk) begin
    // Outputs stay low through reset and the first select cycle
    if (rst_seen && (!s_rst_n || !rst_prev)) begin
      if (insn_rdy_i !== 1'b0) report_mismatch("reset insn_rdy_o", 0, insn_rdy_i);
      if (pem_vld_i !== 1'b0)  report_mismatch("reset pem_vld_o", 0, pem_vld_i);
      if (pea_vld_i !== 1'b0)  report_mismatch("reset pea_vld_o", 0, pea_vld_i);
      if (pep_vld_i !== 1'b0)  report_mismatch("reset pep_vld_o", 0, pep_vld_i);
      if (ack_vld_i !== 1'b0)  report_mismatch("reset ack_vld_o", 0, ack_vld_i);
    end
    rst_seen = rst_seen || !s_rst_n;
    rst_prev = s_rst_n;

    if (s_rst_n === 1'b1 && rst_seen) begin
      if (insn_vld_i && insn_rdy_i) begin
        if (n_in < INSN_NB) begin
          prog[n_in] = insn_i;
          if (expected_pe(insn_i) < 0)
            n_sync++;
          else
            n_nonsync++;
          n_in++;
        end else begin
          report_failure("input took more instructions than were sent");
        end
      end
      for (int p = 0; p < PE_NB; p++) begin
        // Acks come back in acceptance order
        if (ack[p] === 1'b1) begin
          if (ack_nb[p] < acc_nb[p]) begin
            acked[acc_order[p*INSN_NB + ack_nb[p]]] = 1'b1;
            ack_nb[p]++;
            n_acked++;
          end else begin
            report_failure($sformatf("%s acked with nothing outstanding", pe_name(p)));
          end
        end
        if (hold_vld[p]) begin
          if (vld[p] !== 1'b1)
            report_mismatch($sformatf("backpressure %s_vld_o", pe_name(p)), 1, vld[p]);
          else if (pe_insn[p] != hold_insn[p])
            report_mismatch($sformatf("backpressure %s_insn_o", pe_name(p)),
                            hold_insn[p], pe_insn[p]);
        end
        if (vld[p] === 1'b1 && rdy[p])
          check_accept(p, pe_insn[p]);
        hold_vld[p]  = (vld[p] === 1'b1) && !rdy[p];
        hold_insn[p] = pe_insn[p];
      end
      // Never more SYNC acks than SYNCs that may have completed
      if (ack_vld_i && ack_rdy_i) begin
        ack_sum = ack_sum + int'(ack_cnt_i);
        if (ack_sum > eligible_syncs())
          report_mismatch("sync_ack bound", eligible_syncs(), ack_sum);
      end
    end

    // End of run totals
    if (end_i && !done_o) begin
      if (n_in != INSN_NB)
        report_mismatch("input_count", INSN_NB, n_in);
      for (int k = 0; k < n_in; k++) begin
        if (expected_pe(prog[k]) >= 0 && !accepted[k])
          report_failure($sformatf("instruction #%0d never reached its PE", k));
        else if (expected_pe(prog[k]) >= 0 && !acked[k])
          report_failure($sformatf("instruction #%0d was never acked", k));
      end
      if (ack_sum != n_sync)
        report_mismatch("sync_ack total", n_sync, ack_sum);
      done_o = 1'b1;
    end
  end

endmodule

`default_nettype wire

// ==== testbench/tb_isc_scheduler.sv ====
`default_nettype none
`timescale 1ns/100ps

// PE stand-in with random ready and in-order acks after a random delay
module pe_model (
  input  wire logic clk,
  input  wire logic s_rst_n,
  input  wire logic vld_i,
  output logic      rdy_o,
  output logic      ack_o
);

  // Completion cycles of accepted instructions in acceptance order
  int unsigned due_q[$];
  int unsigned cyc;
  int unsigned due;

  initial begin
    rdy_o = 1'b0;
    ack_o = 1'b0;
    cyc   = 0;
  end

  always @(posedge clk) begin
    cyc = cyc + 1;
    if (s_rst_n && vld_i && rdy_o) begin
      due = cyc + $urandom_range(1, 20);
      // Keep acceptance order and at most one ack per cycle
      if (due_q.size() > 0 && due <= due_q[due_q.size()-1])
        due = due_q[due_q.size()-1] + 1;
      due_q.push_back(due);
    end
    #0.5;
    ack_o = 1'b0;
    if (due_q.size() > 0 && due_q[0] <= cyc) begin
      ack_o = 1'b1;
      void'(due_q.pop_front());
    end
    rdy_o = ($urandom_range(0, 3) != 0);
  end

endmodule

module tb_isc_scheduler
  import isc_pkg::*;
;

  localparam int          INSN_NB      = 300;
  localparam int          CLK_PERIOD   = 4;
  localparam int          TIMEOUT_NS   = INSN_NB * 60 * CLK_PERIOD;
  localparam int          DRAIN_CYCLES = 2000;
  localparam int unsigned SEED         = 32'ha601cd17;

  logic      clk = 1'b0;
  logic      s_rst_n;
  insn_t     insn_i;
  logic      insn_vld_i;
  logic      insn_rdy_o;
  logic      ack_rdy_i;
  logic      ack_vld_o;
  ack_cnt_t  ack_cnt_o;
  logic      pem_rdy_i;
  logic      pea_rdy_i;
  logic      pep_rdy_i;
  logic      pem_vld_o;
  logic      pea_vld_o;
  logic      pep_vld_o;
  insn_t     pem_insn_o;
  insn_t     pea_insn_o;
  insn_t     pep_insn_o;
  logic      pem_ack_i;
  logic      pea_ack_i;
  logic      pep_ack_i;
  logic      end_run;
  logic      drained;
  logic      chk_done;
  int        err_cnt;
  int        drain_cyc;
  int unsigned seed_ret;

  always #2 clk = ~clk;

  // Random kind with about one SYNC in ten and registers from a narrow range
  function automatic insn_t random_insn();
    insn_t       insn;
    int unsigned r;
    r = $urandom_range(0, 9);
    insn[KIND_MSB -: 2]          = (r == 0) ? KIND_SYNC : 2'(1 + (r - 1) % 3);
    insn[DST_LSB +: REG_ID_W]    = reg_id_t'($urandom_range(0, 5));
    insn[SRCA_LSB +: REG_ID_W]   = reg_id_t'($urandom_range(0, 5));
    insn[SRCB_LSB +: REG_ID_W]   = reg_id_t'($urandom_range(0, 5));
    insn[1:0]                    = 2'($urandom_range(0, 3));
    return insn;
  endfunction

  // ----------------------------------------------------------------------
  // DUT, PE models and checker
  // ----------------------------------------------------------------------
  isc_scheduler i_isc_scheduler (
    .clk (clk), .s_rst_n (s_rst_n),
    .insn_i (insn_i), .insn_vld_i (insn_vld_i), .insn_rdy_o (insn_rdy_o),
    .ack_rdy_i (ack_rdy_i), .ack_vld_o (ack_vld_o), .ack_cnt_o (ack_cnt_o),
    .pem_rdy_i (pem_rdy_i), .pem_vld_o (pem_vld_o), .pem_insn_o (pem_insn_o),
    .pem_ack_i (pem_ack_i),
    .pea_rdy_i (pea_rdy_i), .pea_vld_o (pea_vld_o), .pea_insn_o (pea_insn_o),
    .pea_ack_i (pea_ack_i),
    .pep_rdy_i (pep_rdy_i), .pep_vld_o (pep_vld_o), .pep_insn_o (pep_insn_o),
    .pep_ack_i (pep_ack_i)
  );

  pe_model i_pem (.clk (clk), .s_rst_n (s_rst_n), .vld_i (pem_vld_o),
                  .rdy_o (pem_rdy_i), .ack_o (pem_ack_i));
  pe_model i_pea (.clk (clk), .s_rst_n (s_rst_n), .vld_i (pea_vld_o),
                  .rdy_o (pea_rdy_i), .ack_o (pea_ack_i));
  pe_model i_pep (.clk (clk), .s_rst_n (s_rst_n), .vld_i (pep_vld_o),
                  .rdy_o (pep_rdy_i), .ack_o (pep_ack_i));

  isc_checker #(.INSN_NB (INSN_NB)) i_isc_checker (
    .clk (clk), .s_rst_n (s_rst_n),
    .insn_i (insn_i), .insn_vld_i (insn_vld_i), .insn_rdy_i (insn_rdy_o),
    .pem_vld_i (pem_vld_o), .pem_rdy_i (pem_rdy_i), .pem_insn_i (pem_insn_o),
    .pem_ack_i (pem_ack_i),
    .pea_vld_i (pea_vld_o), .pea_rdy_i (pea_rdy_i), .pea_insn_i (pea_insn_o),
    .pea_ack_i (pea_ack_i),
    .pep_vld_i (pep_vld_o), .pep_rdy_i (pep_rdy_i), .pep_insn_i (pep_insn_o),
    .pep_ack_i (pep_ack_i),
    .ack_vld_i (ack_vld_o), .ack_rdy_i (ack_rdy_i), .ack_cnt_i (ack_cnt_o),
    .end_i (end_run), .drained_o (drained), .done_o (chk_done), .err_cnt_o (err_cnt)
  );

  // Host side of the SYNC ack stream
  always @(posedge clk) begin
    #0.5;
    ack_rdy_i = $urandom_range(0, 1);
  end

  // ----------------------------------------------------------------------
  // Main sequence
  // ----------------------------------------------------------------------
  initial begin
    seed_ret   = $urandom(SEED);
    s_rst_n    = 1'b0;
    insn_i     = '0;
    insn_vld_i = 1'b0;
    ack_rdy_i  = 1'b0;
    end_run    = 1'b0;
    drain_cyc  = 0;
    repeat (8) @(posedge clk);
    #0.5;
    s_rst_n = 1'b1;

    for (int i = 0; i < INSN_NB; i++) begin
      // Random idle gap before each instruction
      repeat ($urandom_range(0, 3)) @(posedge clk);
      #0.5;
      insn_i     = random_insn();
      insn_vld_i = 1'b1;
      // Hold until the ready pulse takes it
      @(posedge clk);
      while (!insn_rdy_o)
        @(posedge clk);
      #0.5;
      insn_vld_i = 1'b0;
    end

    // Give the pool, the PEs and the ack stream time to drain
    while (!drained && drain_cyc < DRAIN_CYCLES) begin
      @(posedge clk);
      #0.5;
      drain_cyc++;
    end
    repeat (4) @(posedge clk);
    #0.5;
    end_run = 1'b1;
    wait (chk_done);
    $display("Summary: %0d instructions, %0d errors", INSN_NB, err_cnt);
    if (err_cnt == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

  // Watchdog sized on 60 cycles per instruction
  initial begin
    #(TIMEOUT_NS);
    $display("Run timed out after %0d ns with instructions still outstanding", TIMEOUT_NS);
    $display("ERRORS FOUND");
    $finish;
  end

endmodule

`default_nettype wire
